//--- int_div_queue.f
int_div_pkg.sv
op_ram.sv
op_fifo.sv
div_core.sv
div_engine.sv
int_div_queue.sv
int_div_queue_assert.sv
tb_int_div_queue.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f int_div_queue.f \
    --top-module tb_int_div_queue \
    -o sim_int_div_queue
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_int_div_queue > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- tb_int_div_queue.sv
`default_nettype none

module tb_int_div_queue;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 8;
    localparam int N_UNSIGNED = 12;
    localparam int N_SIGNED = 12;
    localparam int N_BURST = 14;
    localparam int N_CORNER = 9;
    localparam int N_TOTAL = N_UNSIGNED + N_SIGNED + N_BURST + N_CORNER;
    localparam int TIMEOUT_CYCLES = (N_TOTAL + 4) * 30;

    logic                clk;
    logic                rst;
    logic                push;
    logic                push_signed;
    int_div_pkg::data_t  push_dividend;
    int_div_pkg::data_t  push_divisor;
    logic                full;
    logic                empty;
    logic                result_valid;
    int_div_pkg::data_t  result_quotient;
    logic                result_signed;

    // Accepted requests, oldest first.
    int_div_pkg::entry_t pending [$];
    string               test_name;
    logic                full_seen;
    int                  n_checked;

    int_div_queue u_int_div_queue (
        .clk             (clk),
        .rst             (rst),
        .push            (push),
        .push_signed     (push_signed),
        .push_dividend   (push_dividend),
        .push_divisor    (push_divisor),
        .full            (full),
        .empty           (empty),
        .result_valid    (result_valid),
        .result_quotient (result_quotient),
        .result_signed   (result_signed)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // Reference and checks.
    ////////////////////

    // Truncation toward zero on magnitudes; zero divisor gives all ones.
    function automatic int_div_pkg::data_t ref_div(
        input logic               sgn,
        input int_div_pkg::data_t a,
        input int_div_pkg::data_t b
    );
        logic               neg_a;
        logic               neg_b;
        int_div_pkg::data_t mag_a;
        int_div_pkg::data_t mag_b;
        int_div_pkg::data_t mag_q;
        neg_a = sgn && a[int_div_pkg::DATA_W-1];
        neg_b = sgn && b[int_div_pkg::DATA_W-1];
        mag_a = neg_a ? int_div_pkg::data_t'(0) - a : a;
        mag_b = neg_b ? int_div_pkg::data_t'(0) - b : b;
        if (mag_b == '0) begin
            mag_q = '1;
        end else begin
            mag_q = mag_a / mag_b;
        end
        return (neg_a ^ neg_b) ? int_div_pkg::data_t'(0) - mag_q : mag_q;
    endfunction

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_quotient(
        input string              name,
        input int_div_pkg::data_t expected,
        input int_div_pkg::data_t actual
    );
        if (actual !== expected) begin
            $display("FAILED %s: quotient expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: flag expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    // Record each accepted push.
    always @(negedge clk) begin
        if (!rst && push && !full) begin
            pending.push_back({push_signed, push_dividend, push_divisor});
        end
    end

    // Compare each result with the oldest request.
    always @(negedge clk) begin
        int_div_pkg::entry_t req;
        if (!rst && result_valid) begin
            if (pending.size() == 0) begin
                $display("A result came out with no request outstanding.");
                abort_run();
            end
            req = pending.pop_front();
            check_quotient(test_name,
                           ref_div(req[int_div_pkg::ENTRY_MODE_BIT],
                                   req[int_div_pkg::ENTRY_DIVIDEND_LSB +: int_div_pkg::DATA_W],
                                   req[int_div_pkg::ENTRY_DIVISOR_LSB +: int_div_pkg::DATA_W]),
                           result_quotient);
            check_flag(test_name, req[int_div_pkg::ENTRY_MODE_BIT], result_signed);
            n_checked++;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d results outstanding.",
                 TIMEOUT_CYCLES, pending.size());
        $display("sim failed");
        $fatal(1, "Watchdog expired.");
    end

    ////////////////////
    // Stimulus.
    ////////////////////

    // Hold the request until a cycle with full low.
    task automatic push_req(
        input logic               sgn,
        input int_div_pkg::data_t a,
        input int_div_pkg::data_t b
    );
        logic accepted;
        accepted = 1'b0;
        push = 1'b1;
        push_signed = sgn;
        push_dividend = a;
        push_divisor = b;
        while (!accepted) begin
            @(negedge clk);
            accepted = !full;
            @(posedge clk);
            #1;
        end
        push = 1'b0;
    endtask

    task automatic idle_gap();
        int gap;
        gap = $urandom % 4;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        while (pending.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    initial begin
        int_div_pkg::data_t a;
        int_div_pkg::data_t b;
        void'($urandom(37));
        rst = 1'b1;
        push = 1'b0;
        push_signed = 1'b0;
        push_dividend = '0;
        push_divisor = '0;
        full_seen = 1'b0;
        n_checked = 0;
        test_name = "reset";
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle queue after reset.
        @(negedge clk);
        check_flag("reset empty", 1'b1, empty);
        check_flag("reset full", 1'b0, full);
        repeat (10) @(posedge clk);
        #1;

        test_name = "unsigned random";
        for (int i = 0; i < N_UNSIGNED; i++) begin
            a = int_div_pkg::data_t'($urandom);
            b = int_div_pkg::data_t'($urandom) >> ($urandom % 24);
            push_req(1'b0, a, b);
            idle_gap();
        end
        wait_drain();

        // All four sign combinations in turn.
        test_name = "signed random";
        for (int i = 0; i < N_SIGNED; i++) begin
            a = int_div_pkg::data_t'($urandom) >> 1;
            b = (int_div_pkg::data_t'($urandom) >> (1 + $urandom % 22)) | int_div_pkg::data_t'(1);
            if (i % 2 == 1) begin
                a = int_div_pkg::data_t'(0) - a;
            end
            if (i % 4 >= 2) begin
                b = int_div_pkg::data_t'(0) - b;
            end
            push_req(1'b1, a, b);
            idle_gap();
        end
        wait_drain();

        // Back to back, no retry on refusal.
        test_name = "burst";
        for (int i = 0; i < N_BURST; i++) begin
            push = 1'b1;
            push_signed = i[0];
            push_dividend = int_div_pkg::data_t'($urandom);
            push_divisor = int_div_pkg::data_t'($urandom) >> (4 + $urandom % 16);
            @(negedge clk);
            if (full) begin
                full_seen = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        push = 1'b0;
        wait_drain();

        test_name = "corner";
        push_req(1'b1, 24'd5, 24'd0);
        push_req(1'b1, 24'hfffffb, 24'd0);
        push_req(1'b0, 24'd5, 24'd0);
        push_req(1'b0, 24'd0, 24'd0);
        push_req(1'b1, 24'h800000, 24'hffffff);
        push_req(1'b0, 24'h800000, 24'hffffff);
        push_req(1'b0, 24'd3, 24'd7);
        push_req(1'b1, 24'hfffffd, 24'd7);
        push_req(1'b1, 24'd3, 24'hfffff9);
        wait_drain();

        if (!full_seen) begin
            $display("The burst never saw full high.");
            $display("sim failed");
            $fatal(1, "Burst did not fill the queue.");
        end else begin
            $display("Checked %0d results.", n_checked);
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- int_div_queue_assert.sv
`default_nettype none

module int_div_queue_assert (
    input wire                      clk,
    input wire                      rst,
    input wire                      full,
    input wire                      empty,
    input wire                      result_valid,
    input wire                      core_start,
    input wire                      core_done,
    input wire int_div_pkg::count_t fifo_count
);

    timeunit 1ns;
    timeprecision 100ps;

    ////////////////////
    // Queue flags.
    ////////////////////

    full_not_empty: assert property (@(posedge clk) disable iff (rst) !(full && empty))
        else $error("full and empty are high together");

    count_in_range: assert property (@(posedge clk) disable iff (rst)
        fifo_count <= int_div_pkg::count_t'(int_div_pkg::DEPTH))
        else $error("FIFO count above depth");

    ////////////////////
    // Engine timing.
    ////////////////////

    result_one_cycle: assert property (@(posedge clk) disable iff (rst)
        result_valid |=> !result_valid)
        else $error("result_valid held longer than one cycle");

    // Divider latency is fixed.
    done_after_start: assert property (@(posedge clk) disable iff (rst)
        core_start |-> ##(int_div_pkg::DATA_W) core_done)
        else $error("divider done not DATA_W cycles after start");

endmodule

bind int_div_queue int_div_queue_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .full         (full),
    .empty        (empty),
    .result_valid (result_valid),
    .core_start   (core_start),
    .core_done    (core_done),
    .fifo_count   (u_fifo.count)
);

`default_nettype wire

//--- int_div_queue.sv
`default_nettype none

module int_div_queue (
    input  wire                     clk,
    input  wire                     rst,

    // Requests.
    input  wire                     push,
    input  wire                     push_signed,
    input  wire int_div_pkg::data_t push_dividend,
    input  wire int_div_pkg::data_t push_divisor,
    output logic                    full,
    output logic                    empty,

    // Results.
    output logic                    result_valid,
    output int_div_pkg::data_t      result_quotient,
    output logic                    result_signed
);

    int_div_pkg::entry_t push_data;
    int_div_pkg::entry_t pop_data;
    logic                pop;

    int_div_pkg::addr_t  ram_addr;
    int_div_pkg::entry_t ram_wdata;
    int_div_pkg::entry_t ram_rdata;
    logic                ram_we;
    logic                ram_re;

    logic                core_start;
    logic                core_signed;
    int_div_pkg::data_t  core_dividend;
    int_div_pkg::data_t  core_divisor;
    int_div_pkg::data_t  core_quotient;
    logic                core_done;

    // Mode, dividend, divisor.
    assign push_data = {push_signed, push_dividend, push_divisor};

    op_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty),
        .full      (full),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata),
        .ram_we    (ram_we),
        .ram_re    (ram_re)
    );

    op_ram u_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata),
        .we    (ram_we),
        .re    (ram_re)
    );

    div_engine u_engine (
        .clk             (clk),
        .rst             (rst),
        .empty           (empty),
        .pop             (pop),
        .pop_data        (pop_data),
        .core_start      (core_start),
        .core_signed     (core_signed),
        .core_dividend   (core_dividend),
        .core_divisor    (core_divisor),
        .core_quotient   (core_quotient),
        .core_done       (core_done),
        .result_valid    (result_valid),
        .result_quotient (result_quotient),
        .result_signed   (result_signed)
    );

    div_core u_core (
        .clk       (clk),
        .rst       (rst),
        .start     (core_start),
        .is_signed (core_signed),
        .dividend  (core_dividend),
        .divisor   (core_divisor),
        .quotient  (core_quotient),
        .done      (core_done)
    );

endmodule

`default_nettype wire

//--- div_engine.sv
`default_nettype none

module div_engine (
    input  wire                      clk,
    input  wire                      rst,

    // Queue side.
    input  wire                      empty,
    output logic                     pop,
    input  wire int_div_pkg::entry_t pop_data,

    // Divider side.
    output logic                     core_start,
    output logic                     core_signed,
    output int_div_pkg::data_t       core_dividend,
    output int_div_pkg::data_t       core_divisor,
    input  wire int_div_pkg::data_t  core_quotient,
    input  wire                      core_done,

    // Result.
    output logic                     result_valid,
    output int_div_pkg::data_t       result_quotient,
    output logic                     result_signed
);

    int_div_pkg::engine_state_t state;

    ////////////////////
    // FSM.
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= int_div_pkg::ENG_IDLE;
        end else begin
            case (state)
                int_div_pkg::ENG_IDLE: begin
                    if (!empty) begin
                        state <= int_div_pkg::ENG_FETCH;
                    end
                end
                int_div_pkg::ENG_FETCH: begin
                    state <= int_div_pkg::ENG_RUN;
                end
                int_div_pkg::ENG_RUN: begin
                    if (core_done) begin
                        state <= int_div_pkg::ENG_DONE;
                    end
                end
                default: begin
                    state <= int_div_pkg::ENG_IDLE;
                end
            endcase
        end
    end

    assign pop = (state == int_div_pkg::ENG_IDLE) & ~empty;

    // Entry is on pop_data during FETCH.
    assign core_start = (state == int_div_pkg::ENG_FETCH);
    assign core_signed = pop_data[int_div_pkg::ENTRY_MODE_BIT];
    assign core_dividend = pop_data[int_div_pkg::ENTRY_DIVIDEND_LSB +: int_div_pkg::DATA_W];
    assign core_divisor = pop_data[int_div_pkg::ENTRY_DIVISOR_LSB +: int_div_pkg::DATA_W];

    ////////////////////
    // Result capture.
    ////////////////////

    // pop_data holds until the next pop, so the mode is still there.
    always_ff @(posedge clk) begin
        if (state == int_div_pkg::ENG_RUN && core_done) begin
            result_quotient <= core_quotient;
            result_signed <= pop_data[int_div_pkg::ENTRY_MODE_BIT];
        end
    end

    assign result_valid = (state == int_div_pkg::ENG_DONE);

endmodule

`default_nettype wire

//--- div_core.sv
`default_nettype none

module div_core (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start,
    input  wire                     is_signed,
    input  wire int_div_pkg::data_t dividend,
    input  wire int_div_pkg::data_t divisor,
    output int_div_pkg::data_t      quotient,
    output logic                    done
);

    // Partial remainder, shifting quotient and stored divisor magnitude.
    int_div_pkg::data_t rem;
    int_div_pkg::data_t quo;
    int_div_pkg::data_t dvs;
    logic               negate;
    int_div_pkg::step_t step;

    int_div_pkg::data_t a_mag;
    int_div_pkg::data_t b_mag;

    logic [2*int_div_pkg::DATA_W-1:0] first;
    logic [2*int_div_pkg::DATA_W-1:0] next;

    // One restoring step, returns {remainder, quotient}.
    function automatic logic [2*int_div_pkg::DATA_W-1:0] div_step(
        input int_div_pkg::data_t r,
        input int_div_pkg::data_t q,
        input int_div_pkg::data_t d
    );
        logic [int_div_pkg::DATA_W:0]   trial;
        logic [int_div_pkg::DATA_W+1:0] diff;
        trial = {r, q[int_div_pkg::DATA_W-1]};
        diff = {1'b0, trial} - {2'b00, d};
        if (diff[int_div_pkg::DATA_W+1]) begin
            return {trial[int_div_pkg::DATA_W-1:0], q[int_div_pkg::DATA_W-2:0], 1'b0};
        end
        return {diff[int_div_pkg::DATA_W-1:0], q[int_div_pkg::DATA_W-2:0], 1'b1};
    endfunction

    ////////////////////
    // Operand magnitudes.
    ////////////////////

    assign a_mag = (is_signed && dividend[int_div_pkg::DATA_W-1]) ? -dividend : dividend;
    assign b_mag = (is_signed && divisor[int_div_pkg::DATA_W-1]) ? -divisor : divisor;

    // The load cycle already does the first step.
    assign first = div_step('0, a_mag, b_mag);
    assign next = div_step(rem, quo, dvs);

    ////////////////////
    // Datapath.
    ////////////////////

    always_ff @(posedge clk) begin
        if (start) begin
            {rem, quo} <= first;
            dvs <= b_mag;
            negate <= is_signed
                      & (dividend[int_div_pkg::DATA_W-1] ^ divisor[int_div_pkg::DATA_W-1]);
        end else if (step != '0) begin
            {rem, quo} <= next;
        end
    end

    ////////////////////
    // Step counter.
    ////////////////////

    // Remaining steps after the load, done lands DATA_W cycles after start.
    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= (step == int_div_pkg::step_t'(1));
            if (start) begin
                step <= int_div_pkg::step_t'(int_div_pkg::DATA_W - 1);
            end else if (step != '0) begin
                step <= step - 1'b1;
            end
        end
    end

    // Sign fix on the magnitude.
    assign quotient = negate ? -quo : quo;

endmodule

`default_nettype wire

//--- op_fifo.sv
`default_nettype none

module op_fifo (
    input  wire                      clk,
    input  wire                      rst,

    // Producer side.
    input  wire                      push,
    input  wire int_div_pkg::entry_t push_data,

    // Consumer side.
    input  wire                      pop,
    output int_div_pkg::entry_t      pop_data,

    output logic                     empty,
    output logic                     full,

    // RAM port.
    output int_div_pkg::addr_t       ram_addr,
    output int_div_pkg::entry_t      ram_wdata,
    input  wire int_div_pkg::entry_t ram_rdata,
    output logic                     ram_we,
    output logic                     ram_re
);

    int_div_pkg::addr_t  rd_ptr;
    int_div_pkg::addr_t  wr_ptr;
    int_div_pkg::count_t count;

    logic do_pop;
    logic do_push;

    ////////////////////
    // Flags.
    ////////////////////

    assign empty = (count == '0);

    // A pop takes the single RAM port, so a push is refused that cycle.
    assign do_pop = pop & ~empty;
    assign full = (count == int_div_pkg::count_t'(int_div_pkg::DEPTH)) | do_pop;
    assign do_push = push & ~full;

    ////////////////////
    // RAM access.
    ////////////////////

    assign ram_re = do_pop;
    assign ram_we = do_push;
    assign ram_wdata = push_data;

    always_comb begin
        if (ram_re) begin
            ram_addr = rd_ptr;
        end else begin
            ram_addr = wr_ptr;
        end
    end

    // Read data comes straight from the RAM register.
    assign pop_data = ram_rdata;

    ////////////////////
    // Pointers.
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    ////////////////////
    // Occupancy.
    ////////////////////

    // Push and pop never land in the same cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({do_pop, do_push})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- op_ram.sv
`default_nettype none

module op_ram (
    input  wire                 clk,
    input  wire int_div_pkg::addr_t  addr,
    input  wire int_div_pkg::entry_t wdata,
    output int_div_pkg::entry_t      rdata,
    input  wire                 we,
    input  wire                 re
);

    int_div_pkg::entry_t mem [int_div_pkg::DEPTH];

    // Write port.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Registered read, held until the next read.
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- int_div_pkg.sv
`default_nettype none

package int_div_pkg;

    ////////////////////
    // Sizes.
    ////////////////////

    // Operand and quotient width.
    localparam int DATA_W = 24;

    // Queue addressing.
    localparam int ADDR_W = 3;
    localparam int DEPTH = 1 << ADDR_W;

    // One mode bit plus two operands.
    localparam int ENTRY_W = 1 + 2 * DATA_W;

    // Enough bits to count DATA_W steps.
    localparam int STEP_W = $clog2(DATA_W + 1);

    ////////////////////
    // Entry layout.
    ////////////////////

    // Mode bit on top, then dividend, then divisor.
    localparam int ENTRY_MODE_BIT = ENTRY_W - 1;
    localparam int ENTRY_DIVIDEND_LSB = DATA_W;
    localparam int ENTRY_DIVISOR_LSB = 0;

    ////////////////////
    // Types.
    ////////////////////

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ADDR_W:0] count_t;
    typedef logic [ENTRY_W-1:0] entry_t;
    typedef logic [STEP_W-1:0] step_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_FETCH,
        ENG_RUN,
        ENG_DONE
    } engine_state_t;

endpackage

`default_nettype wire
